//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

    ////////////////////////////////////////////////////////////////////
    // Register index and instruction formats
    ////////////////////////////////////////////////////////////////////

    // Index into the 32-entry register bank
    typedef logic [4:0] reg_idx_t;

    // R-format view of an instruction word
    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // I-format view, immediate in the low half
    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Same 32 bits, two decodings
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } mips_instr_t;

    ////////////////////////////////////////////////////////////////////
    // Opcodes and functs
    ////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0A;
    localparam logic [5:0] OP_ANDI  = 6'h0C;
    localparam logic [5:0] OP_ORI   = 6'h0D;
    localparam logic [5:0] OP_XORI  = 6'h0E;
    localparam logic [5:0] OP_LUI   = 6'h0F;

    // R-type funct field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2A;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

endpackage

`default_nettype wire

//--- reg_port_if.sv
`default_nettype none

interface reg_port_if #(
    parameter int DATA_WIDTH = 32
);
    import mips_pkg::*;

    // Read addresses, from the decoder
    reg_idx_t                rs;
    reg_idx_t                rt;
    // Write port, from the bus slave
    reg_idx_t                rd;
    logic                    we;
    logic [DATA_WIDTH - 1:0] wdata;
    // Read data back from the bank
    logic [DATA_WIDTH - 1:0] rdata_a;
    logic [DATA_WIDTH - 1:0] rdata_b;

    modport bank (input rs, rt, rd, we, wdata, output rdata_a, rdata_b);

    modport core (output rs, rt, rd, we, wdata, input rdata_a, rdata_b);

endinterface

`default_nettype wire

//--- mips_reg_bank.sv
`default_nettype none

module mips_reg_bank #(
    parameter int DATA_WIDTH = 32
) (
    input  wire logic                    i_clock,
    input  wire logic                    i_reset,
    reg_port_if.bank                     port_rf,
    // Debug read, driven from the bus address
    input  wire mips_pkg::reg_idx_t      i_dbg_idx,
    output logic [DATA_WIDTH - 1:0]      o_dbg_data
);
    import mips_pkg::*;

    localparam int NUM_REGS = 32;

    ////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////

    logic [DATA_WIDTH - 1:0] regs [NUM_REGS];
    logic                    wr_en;

    // Register 0 is never a write target
    assign wr_en = port_rf.we && (port_rf.rd != reg_idx_t'(0));

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            // Whole bank back to zero
            for (int idx = 0; idx < NUM_REGS; idx++) begin
                regs[idx] <= '0;
            end
        end else if (wr_en) begin
            regs[port_rf.rd] <= port_rf.wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////////////

    // Operand A, from rs
    assign port_rf.rdata_a = regs[port_rf.rs];

    // Operand B, from rt
    assign port_rf.rdata_b = regs[port_rf.rt];

    // Host side register peek
    assign o_dbg_data = regs[i_dbg_idx];

endmodule

`default_nettype wire

//--- mips_decoder.sv
`default_nettype none

module mips_decoder (
    input  wire mips_pkg::mips_instr_t i_instr,
    reg_port_if.core                   port_rf,
    output mips_pkg::alu_op_e          o_alu_op,
    output logic                       o_use_imm,
    output logic                       o_imm_signed,
    output logic                       o_use_shamt,
    output mips_pkg::reg_idx_t         o_dest,
    output logic                       o_illegal
);
    import mips_pkg::*;

    logic is_rtype;

    // Opcode sits at the same bits in both views
    assign is_rtype = (i_instr.r.opcode == OP_RTYPE);

    // Source registers, rs and rt share their bits in both views
    assign port_rf.rs = i_instr.r.rs;
    assign port_rf.rt = i_instr.r.rt;

    always_comb begin
        // Defaults, I-type add with zero extension
        o_alu_op     = ALU_ADD;
        o_use_imm    = 1'b1;
        o_imm_signed = 1'b0;
        o_use_shamt  = 1'b0;
        o_illegal    = 1'b0;
        o_dest       = i_instr.i.rt;

        if (is_rtype) begin
            // R-type writes rd, B from rt
            o_use_imm = 1'b0;
            o_dest    = i_instr.r.rd;
            case (i_instr.r.funct)
                FN_ADDU: o_alu_op = ALU_ADD;
                FN_SUBU: o_alu_op = ALU_SUB;
                FN_AND:  o_alu_op = ALU_AND;
                FN_OR:   o_alu_op = ALU_OR;
                FN_XOR:  o_alu_op = ALU_XOR;
                FN_NOR:  o_alu_op = ALU_NOR;
                FN_SLT:  o_alu_op = ALU_SLT;
                FN_SLL: begin
                    o_alu_op    = ALU_SLL;
                    o_use_shamt = 1'b1;
                end
                FN_SRL: begin
                    o_alu_op    = ALU_SRL;
                    o_use_shamt = 1'b1;
                end
                default: o_illegal = 1'b1;
            endcase
        end else begin
            case (i_instr.i.opcode)
                // Arithmetic and compare sign-extend
                OP_ADDIU: begin
                    o_alu_op     = ALU_ADD;
                    o_imm_signed = 1'b1;
                end
                OP_SLTI: begin
                    o_alu_op     = ALU_SLT;
                    o_imm_signed = 1'b1;
                end
                // Logic immediates zero-extend
                OP_ANDI: o_alu_op = ALU_AND;
                OP_ORI:  o_alu_op = ALU_OR;
                OP_XORI: o_alu_op = ALU_XOR;
                OP_LUI:  o_alu_op = ALU_LUI;
                default: o_illegal = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- mips_alu.sv
`default_nettype none

module mips_alu #(
    parameter int DATA_WIDTH = 32
) (
    input  wire logic [DATA_WIDTH - 1:0] i_a,
    input  wire logic [DATA_WIDTH - 1:0] i_b,
    input  wire logic [4:0]              i_shamt,
    input  wire mips_pkg::alu_op_e       i_op,
    output logic [DATA_WIDTH - 1:0]      o_result
);
    import mips_pkg::*;

    logic                    a_lt_b;
    logic [DATA_WIDTH - 1:0] lui_val;

    // Signed compare for SLT and SLTI
    assign a_lt_b = ($signed(i_a) < $signed(i_b));

    // Low immediate half moved to the top
    assign lui_val = DATA_WIDTH'(i_b[15:0]) << 16;

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_XOR: o_result = i_a ^ i_b;
            ALU_NOR: o_result = ~(i_a | i_b);
            // 1 or 0, nothing else
            ALU_SLT: o_result = DATA_WIDTH'(a_lt_b);
            // Shifts act on rt
            ALU_SLL: o_result = i_b << i_shamt;
            ALU_SRL: o_result = i_b >> i_shamt;
            ALU_LUI: o_result = lui_val;
            default: o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- mips_wb_slave.sv
`default_nettype none

module mips_wb_slave #(
    parameter int DATA_WIDTH = 32
) (
    input  wire logic                    i_clock,
    input  wire logic                    i_reset,
    // Wishbone classic slave
    input  wire logic                    i_wb_cyc,
    input  wire logic                    i_wb_stb,
    input  wire logic                    i_wb_we,
    input  wire logic [5:0]              i_wb_adr,
    input  wire logic [DATA_WIDTH - 1:0] i_wb_dat,
    output logic [DATA_WIDTH - 1:0]      o_wb_dat,
    output logic                         o_wb_ack,
    output logic                         o_wb_err,
    // Execute path
    output mips_pkg::mips_instr_t        o_instr,
    input  wire logic [DATA_WIDTH - 1:0] i_result,
    input  wire mips_pkg::reg_idx_t      i_dest,
    input  wire logic                    i_illegal,
    reg_port_if.core                     port_rf,
    // Register peek
    output mips_pkg::reg_idx_t           o_dbg_idx,
    input  wire logic [DATA_WIDTH - 1:0] i_dbg_data
);
    import mips_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_RESP
    } state_e;

    state_e      state;
    mips_instr_t instr_q;
    logic        req;
    logic        wr_instr;
    logic        rd_reg;

    // Only sampled in idle, so one transfer at a time
    assign req      = i_wb_cyc && i_wb_stb && (state == ST_IDLE);
    assign wr_instr = i_wb_we && (i_wb_adr == 6'd0);
    // Upper half of the map is the register window
    assign rd_reg   = !i_wb_we && i_wb_adr[5];

    assign o_dbg_idx = i_wb_adr[4:0];
    assign o_instr   = instr_q;

    ////////////////////////////////////////////////////////////////////
    // Writeback to the bank
    ////////////////////////////////////////////////////////////////////

    // Write lands on the same edge that raises ack
    assign port_rf.rd    = i_dest;
    assign port_rf.wdata = i_result;
    assign port_rf.we    = (state == ST_EXEC) && !i_illegal;

    ////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state    <= ST_IDLE;
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        if (wr_instr) begin
                            state <= ST_EXEC;
                        end else if (rd_reg) begin
                            o_wb_ack <= 1'b1;
                            state    <= ST_RESP;
                        end else begin
                            // Bad address or direction
                            o_wb_err <= 1'b1;
                            state    <= ST_RESP;
                        end
                    end
                end
                ST_EXEC: begin
                    o_wb_ack <= !i_illegal;
                    o_wb_err <= i_illegal;
                    state    <= ST_RESP;
                end
                ST_RESP: begin
                    // Single-cycle response, stb ignored here
                    o_wb_ack <= 1'b0;
                    o_wb_err <= 1'b0;
                    state    <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Instruction word and read data
    always_ff @(posedge i_clock) begin
        if (req && wr_instr) begin
            instr_q <= mips_instr_t'(i_wb_dat[31:0]);
        end
        if (req && rd_reg) begin
            o_wb_dat <= i_dbg_data;
        end
    end

endmodule

`default_nettype wire

//--- mips_exec_top.sv
`default_nettype none

module mips_exec_top #(
    parameter int DATA_WIDTH = 32
) (
    input  wire logic                    i_clock,
    input  wire logic                    i_reset,
    input  wire logic                    i_wb_cyc,
    input  wire logic                    i_wb_stb,
    input  wire logic                    i_wb_we,
    input  wire logic [5:0]              i_wb_adr,
    input  wire logic [DATA_WIDTH - 1:0] i_wb_dat,
    output logic [DATA_WIDTH - 1:0]      o_wb_dat,
    output logic                         o_wb_ack,
    output logic                         o_wb_err
);
    import mips_pkg::*;

    mips_instr_t             instr;
    alu_op_e                 alu_op;
    logic                    use_imm;
    logic                    imm_signed;
    logic                    use_shamt;
    reg_idx_t                dest;
    logic                    illegal;
    logic [DATA_WIDTH - 1:0] result;
    reg_idx_t                dbg_idx;
    logic [DATA_WIDTH - 1:0] dbg_data;
    logic [DATA_WIDTH - 1:0] imm_ext;
    logic [DATA_WIDTH - 1:0] alu_b;
    logic [4:0]              alu_shamt;

    reg_port_if #(.DATA_WIDTH(DATA_WIDTH)) rf_if ();

    ////////////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////////////

    // Sign or zero extension of the immediate
    assign imm_ext = imm_signed ? {{(DATA_WIDTH - 16){instr.i.imm[15]}}, instr.i.imm}
                                : {{(DATA_WIDTH - 16){1'b0}}, instr.i.imm};
    assign alu_b     = use_imm ? imm_ext : rf_if.rdata_b;
    // Shift amount only on shift ops
    assign alu_shamt = use_shamt ? instr.r.shamt : 5'd0;

    mips_wb_slave #(.DATA_WIDTH(DATA_WIDTH)) u_wb_slave (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .o_wb_err   (o_wb_err),
        .o_instr    (instr),
        .i_result   (result),
        .i_dest     (dest),
        .i_illegal  (illegal),
        .port_rf    (rf_if.core),
        .o_dbg_idx  (dbg_idx),
        .i_dbg_data (dbg_data)
    );

    mips_decoder u_decoder (
        .i_instr      (instr),
        .port_rf      (rf_if.core),
        .o_alu_op     (alu_op),
        .o_use_imm    (use_imm),
        .o_imm_signed (imm_signed),
        .o_use_shamt  (use_shamt),
        .o_dest       (dest),
        .o_illegal    (illegal)
    );

    mips_alu #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
        .i_a      (rf_if.rdata_a),
        .i_b      (alu_b),
        .i_shamt  (alu_shamt),
        .i_op     (alu_op),
        .o_result (result)
    );

    mips_reg_bank #(.DATA_WIDTH(DATA_WIDTH)) u_reg_bank (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .port_rf    (rf_if.bank),
        .i_dbg_idx  (dbg_idx),
        .o_dbg_data (dbg_data)
    );

endmodule

`default_nettype wire

//--- mips_exec_properties.sv
`default_nettype none

module mips_exec_properties (
    input wire logic               i_clock,
    input wire logic               i_reset,
    input wire logic               i_ack,
    input wire logic               i_err,
    input wire logic               i_we,
    input wire mips_pkg::reg_idx_t i_rd,
    input wire logic               i_reg0_zero
);
    // Failed assertions so far
    int fail_count = 0;

    ////////////////////////////////////////////////////////////////////
    // Bus response rules
    ////////////////////////////////////////////////////////////////////

    // Never both at once
    a_ack_err_excl: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_ack && i_err))
        else begin
            fail_count++;
            $error("ack and err high in the same cycle");
        end

    // Single-cycle pulses
    a_ack_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
        i_ack |=> !i_ack)
        else begin
            fail_count++;
            $error("ack held longer than one cycle");
        end

    a_err_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
        i_err |=> !i_err)
        else begin
            fail_count++;
            $error("err held longer than one cycle");
        end

    ////////////////////////////////////////////////////////////////////
    // Register bank rule
    ////////////////////////////////////////////////////////////////////

    // A write aimed at register 0 leaves it zero
    a_no_zero_write: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_we && (i_rd == 5'd0)) |=> i_reg0_zero)
        else begin
            fail_count++;
            $error("register 0 changed after a write with destination 0");
        end

endmodule

bind mips_exec_top mips_exec_properties u_props (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_ack       (o_wb_ack),
    .i_err       (o_wb_err),
    .i_we        (rf_if.we),
    .i_rd        (rf_if.rd),
    .i_reg0_zero (u_reg_bank.regs[0] == '0)
);

`default_nettype wire

//--- tb_mips_exec.sv
`default_nettype none

module tb_mips_exec;
    import mips_pkg::*;

    localparam int DATA_WIDTH   = 32;
    localparam int RESET_CYCLES = 16;
    localparam int I_REPS       = 8;
    localparam int R_REPS       = 8;
    localparam int MIX_OPS      = 200;
    // Transfers over all six tests, seeding included
    localparam int NUM_XFERS = 32 + 62 + 12 * I_REPS + 18 * R_REPS + 8 + 40 + MIX_OPS + 32;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_XFERS * 20;

    // One finished bus transfer, expected and observed
    typedef struct packed {
        logic                    is_read;
        logic                    exp_ok;
        logic [5:0]              adr;
        logic [3:0]              exp_edges;
        logic [3:0]              edges;
        logic                    got_ack;
        logic                    got_err;
        logic [DATA_WIDTH - 1:0] exp_dat;
        logic [DATA_WIDTH - 1:0] got_dat;
    } xfer_t;

    logic                    i_clock;
    logic                    i_reset;
    logic                    i_wb_cyc;
    logic                    i_wb_stb;
    logic                    i_wb_we;
    logic [5:0]              i_wb_adr;
    logic [DATA_WIDTH - 1:0] i_wb_dat;
    logic [DATA_WIDTH - 1:0] o_wb_dat;
    logic                    o_wb_ack;
    logic                    o_wb_err;

    // Bank contents as the host should see them
    logic [DATA_WIDTH - 1:0] model_regs [32];
    xfer_t                   xfer_q [$];
    event                    xfer_done;
    int                      errors = 0;
    int                      checks = 0;
    int                      issued = 0;
    int                      checked = 0;
    int                      base_errors = 0;
    int                      base_checks = 0;

    mips_exec_top #(.DATA_WIDTH(DATA_WIDTH)) u_mips_exec_top (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .o_wb_err (o_wb_err)
    );

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Instruction builders and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic mips_instr_t make_r(input logic [5:0] funct, input reg_idx_t rs,
                                           input reg_idx_t rt, input reg_idx_t rd,
                                           input logic [4:0] shamt);
        mips_instr_t ins;
        ins.r.opcode = OP_RTYPE;
        ins.r.rs     = rs;
        ins.r.rt     = rt;
        ins.r.rd     = rd;
        ins.r.shamt  = shamt;
        ins.r.funct  = funct;
        return ins;
    endfunction

    function automatic mips_instr_t make_i(input logic [5:0] opcode, input reg_idx_t rs,
                                           input reg_idx_t rt, input logic [15:0] imm);
        mips_instr_t ins;
        ins.i.opcode = opcode;
        ins.i.rs     = rs;
        ins.i.rt     = rt;
        ins.i.imm    = imm;
        return ins;
    endfunction

    function automatic reg_idx_t pick_reg(input int lo);
        return reg_idx_t'($urandom_range(31, lo));
    endfunction

    function automatic logic [5:0] itype_opcode(input int k);
        case (k)
            0: return OP_ADDIU;
            1: return OP_SLTI;
            2: return OP_ANDI;
            3: return OP_ORI;
            4: return OP_XORI;
            default: return OP_LUI;
        endcase
    endfunction

    function automatic logic [5:0] rtype_funct(input int k);
        case (k)
            0: return FN_ADDU;
            1: return FN_SUBU;
            2: return FN_AND;
            3: return FN_OR;
            4: return FN_XOR;
            5: return FN_NOR;
            6: return FN_SLT;
            7: return FN_SLL;
            default: return FN_SRL;
        endcase
    endfunction

    function automatic mips_instr_t random_instr();
        int sel;
        sel = $urandom_range(14, 0);
        if (sel < 9) begin
            return make_r(rtype_funct(sel), pick_reg(0), pick_reg(0), pick_reg(0),
                          5'($urandom()));
        end
        return make_i(itype_opcode(sel - 9), pick_reg(0), pick_reg(0), 16'($urandom()));
    endfunction

    // Expected result of one instruction against the model bank
    function automatic logic [DATA_WIDTH - 1:0] ref_exec(input mips_instr_t ins,
                                                         output logic illegal);
        logic [DATA_WIDTH - 1:0] a;
        logic [DATA_WIDTH - 1:0] b;
        logic [DATA_WIDTH - 1:0] simm;
        logic [DATA_WIDTH - 1:0] zimm;
        logic [DATA_WIDTH - 1:0] res;
        a       = model_regs[ins.r.rs];
        b       = model_regs[ins.r.rt];
        simm    = {{16{ins.i.imm[15]}}, ins.i.imm};
        zimm    = {16'h0000, ins.i.imm};
        res     = '0;
        illegal = 1'b0;
        if (ins.r.opcode == OP_RTYPE) begin
            case (ins.r.funct)
                FN_ADDU: res = a + b;
                FN_SUBU: res = a - b;
                FN_AND:  res = a & b;
                FN_OR:   res = a | b;
                FN_XOR:  res = a ^ b;
                FN_NOR:  res = ~(a | b);
                FN_SLT:  res = {31'b0, ($signed(a) < $signed(b))};
                FN_SLL:  res = b << ins.r.shamt;
                FN_SRL:  res = b >> ins.r.shamt;
                default: illegal = 1'b1;
            endcase
        end else begin
            case (ins.i.opcode)
                OP_ADDIU: res = a + simm;
                OP_SLTI:  res = {31'b0, ($signed(a) < $signed(simm))};
                OP_ANDI:  res = a & zimm;
                OP_ORI:   res = a | zimm;
                OP_XORI:  res = a ^ zimm;
                OP_LUI:   res = {ins.i.imm, 16'h0000};
                default:  illegal = 1'b1;
            endcase
        end
        return res;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Bus handshake
    //////////////////////////////////////////////////////////////////////

    task automatic do_transfer(input logic we, input logic [5:0] adr,
                               input logic [DATA_WIDTH - 1:0] dat, input logic exp_ok,
                               input logic [DATA_WIDTH - 1:0] exp_dat,
                               input logic [3:0] exp_edges);
        xfer_t rec;
        int    edges;
        @(posedge i_clock);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= we;
        i_wb_adr <= adr;
        i_wb_dat <= dat;
        edges = 0;
        // Sample mid-cycle, bounded in case the slave never answers
        do begin
            @(negedge i_clock);
            edges++;
        end while (!o_wb_ack && !o_wb_err && edges < 8);
        rec.is_read   = !we;
        rec.exp_ok    = exp_ok;
        rec.adr       = adr;
        rec.exp_edges = exp_edges;
        rec.edges     = 4'(edges);
        rec.got_ack   = o_wb_ack;
        rec.got_err   = o_wb_err;
        rec.exp_dat   = exp_dat;
        rec.got_dat   = o_wb_dat;
        @(posedge i_clock);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
        xfer_q.push_back(rec);
        issued++;
        -> xfer_done;
    endtask

    task automatic wb_write_instr(input mips_instr_t ins);
        logic                    illegal;
        logic [DATA_WIDTH - 1:0] exp;
        reg_idx_t                dest;
        exp  = ref_exec(ins, illegal);
        dest = (ins.r.opcode == OP_RTYPE) ? ins.r.rd : ins.i.rt;
        if (!illegal && dest != 5'd0) begin
            model_regs[dest] = exp;
        end
        // Capture edge, then commit edge with ack
        do_transfer(1'b1, 6'd0, ins, !illegal, '0, 4'd3);
    endtask

    task automatic wb_read_reg(input reg_idx_t idx);
        do_transfer(1'b0, {1'b1, idx}, '0, 1'b1, model_regs[idx], 4'd2);
    endtask

    // Bad address or direction
    task automatic wb_refused(input logic we, input logic [5:0] adr,
                              input logic [DATA_WIDTH - 1:0] dat);
        do_transfer(we, adr, dat, 1'b0, '0, 4'd2);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_data(input string name, input logic [DATA_WIDTH - 1:0] exp,
                              input logic [DATA_WIDTH - 1:0] got);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: expected 0x%08h, got 0x%08h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_latency(input logic [5:0] adr, input int exp, input int got);
        checks++;
        if (got != exp) begin
            $display("ERROR: access to address 0x%02h answered after %0d cycles, expected %0d",
                     adr, got, exp);
            errors++;
        end
    endtask

    initial begin : compare_proc
        xfer_t rec;
        forever begin
            @(xfer_done);
            while (xfer_q.size() != 0) begin
                rec = xfer_q.pop_front();
                if (!rec.got_ack && !rec.got_err) begin
                    $display("ERROR: access to address 0x%02h got neither ack nor err", rec.adr);
                    errors++;
                end else begin
                    check_status("o_wb_ack", rec.exp_ok, rec.got_ack);
                    check_status("o_wb_err", !rec.exp_ok, rec.got_err);
                    check_latency(rec.adr, int'(rec.exp_edges), int'(rec.edges));
                    if (rec.is_read && rec.exp_ok && rec.got_ack) begin
                        check_data($sformatf("o_wb_dat reg %0d", rec.adr[4:0]),
                                   rec.exp_dat, rec.got_dat);
                    end
                end
                checked++;
            end
        end
    end

    task automatic report_test(input string name);
        @(negedge i_clock);
        $display("test %s: %0d checks, %0d errors", name, checks - base_checks,
                 errors - base_errors);
        base_checks = checks;
        base_errors = errors;
    endtask

    // Whole bank against the model
    task automatic read_all_regs();
        for (int r = 0; r < 32; r++) begin
            wb_read_reg(reg_idx_t'(r));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clock);
        $display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main_proc
        logic [15:0] imm;
        int          sel;
        void'($urandom(32'h7f07));
        i_reset  = 1'b1;
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
        i_wb_adr = '0;
        i_wb_dat = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_reset <= 1'b0;

        // 1. Reset state
        read_all_regs();
        report_test("reset_state");

        // 2. I-type, after loading every register with a random word
        for (int r = 1; r < 32; r++) begin
            wb_write_instr(make_i(OP_LUI, 5'd0, reg_idx_t'(r), 16'($urandom())));
            wb_write_instr(make_i(OP_ORI, reg_idx_t'(r), reg_idx_t'(r), 16'($urandom())));
        end
        for (int k = 0; k < 6; k++) begin
            for (int n = 0; n < I_REPS; n++) begin
                imm = 16'($urandom());
                // Alternate the immediate sign bit
                imm[15] = n[0];
                wb_write_instr(make_i(itype_opcode(k), pick_reg(0), reg_idx_t'(n + 1 + k), imm));
                wb_read_reg(reg_idx_t'(n + 1 + k));
            end
        end
        report_test("itype");

        // 3. R-type
        for (int k = 0; k < 9; k++) begin
            for (int n = 0; n < R_REPS; n++) begin
                wb_write_instr(make_r(rtype_funct(k), pick_reg(0), pick_reg(0),
                                      reg_idx_t'(2 * n + 1 + k), 5'($urandom())));
                wb_read_reg(reg_idx_t'(2 * n + 1 + k));
            end
        end
        report_test("rtype");

        // 4. Destination zero
        wb_write_instr(make_r(FN_ADDU, pick_reg(1), pick_reg(1), 5'd0, 5'd0));
        wb_read_reg(5'd0);
        wb_write_instr(make_i(OP_ORI, pick_reg(1), 5'd0, 16'hffff));
        wb_read_reg(5'd0);
        wb_write_instr(make_i(OP_LUI, 5'd0, 5'd0, 16'h8001));
        wb_read_reg(5'd0);
        wb_write_instr(make_r(FN_NOR, 5'd0, 5'd0, 5'd0, 5'd0));
        wb_read_reg(5'd0);
        report_test("dest_zero");

        // 5. Refused accesses leave the bank untouched
        wb_write_instr(make_r(6'h08, pick_reg(0), pick_reg(0), pick_reg(1), 5'd0));
        wb_write_instr(make_r(6'h18, pick_reg(0), pick_reg(0), pick_reg(1), 5'd0));
        wb_write_instr(make_i(6'h23, pick_reg(0), pick_reg(1), 16'($urandom())));
        wb_write_instr(make_i(6'h02, pick_reg(0), pick_reg(1), 16'($urandom())));
        wb_refused(1'b1, 6'd33, make_i(OP_ADDIU, 5'd0, 5'd1, 16'h1234));
        wb_refused(1'b1, 6'd1, make_i(OP_ADDIU, 5'd0, 5'd2, 16'h1234));
        wb_refused(1'b0, 6'd0, '0);
        wb_refused(1'b0, 6'd7, '0);
        read_all_regs();
        report_test("refused");

        // 6. Random mix with idle gaps
        for (int n = 0; n < MIX_OPS; n++) begin
            repeat ($urandom_range(3, 0)) @(posedge i_clock);
            sel = $urandom_range(9, 0);
            if (sel < 6) begin
                wb_write_instr(random_instr());
            end else if (sel == 6) begin
                wb_write_instr(make_r(6'h3f, pick_reg(0), pick_reg(0), pick_reg(1), 5'd0));
            end else begin
                wb_read_reg(pick_reg(0));
            end
        end
        read_all_regs();
        report_test("random_mix");

        if (checked != issued) begin
            $display("ERROR: %0d transfers issued but only %0d compared", issued, checked);
            errors++;
        end
        $display("total: %0d transfers, %0d checks, %0d errors, %0d assertion failures",
                 issued, checks, errors, u_mips_exec_top.u_props.fail_count);
        if (errors == 0 && u_mips_exec_top.u_props.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
mips_pkg.sv
reg_port_if.sv
mips_reg_bank.sv
mips_decoder.sv
mips_alu.sv
mips_wb_slave.sv
mips_exec_top.sv
mips_exec_properties.sv
tb_mips_exec.sv

//--- Makefile
TOP := tb_mips_exec
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
